//--- compile.f
source/cache_pkg.sv
source/mem_bus_if.sv
source/cache_lookup.sv
source/cache_controller.sv
source/cache_data_array.sv
source/banked_memory.sv
source/cache_top.sv
testbench/cache_properties.sv
testbench/cache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module cache_tb --Mdir "$obj_dir" -o cache_sim -f compile.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$obj_dir/cache_sim" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Simulation failed" "$log_file"; then
    exit 1
fi

exit 0

//--- source/banked_memory.sv
`timescale 1ns/1ns

module banked_memory import cache_pkg::*; (
    input logic clk,
    input logic rst,
    mem_bus_if.memory mem
);

    // consecutive words of a line sit in different banks.
    logic [word_bits-1:0] banks [words_per_line][bank_depth];
    logic [bank_bits-1:0] bank_q;
    logic [row_bits-1:0] row_q;
    logic [word_bits-1:0] data_q;
    logic [mem_read_latency-1:0] pending;
    logic [bank_bits-1:0] bank_sel;
    logic [row_bits-1:0] row_sel;

    assign bank_sel = mem.mem_addr.bank_view.bank;
    assign row_sel = mem.mem_addr.bank_view.row;

    initial begin
        for (int b = 0; b < words_per_line; b++) begin
            for (int r = 0; r < bank_depth; r++) begin
                banks[b][r] = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem.write_mem) begin
            banks[bank_sel][row_sel] <= mem.mem_wdata;
        end
    end

    // stage one holds the location, stage two the word.
    always_ff @(posedge clk) begin
        bank_q <= bank_sel;
        row_q <= row_sel;
        data_q <= banks[bank_q][row_q];
    end

    // tracks which reads are still in flight.
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else begin
            pending <= {pending[mem_read_latency-2:0], mem.read_mem};
        end
    end

    assign mem.mem_rdata = pending[mem_read_latency-1] ? data_q : '0;

endmodule

//--- source/cache_controller.sv
`timescale 1ns/1ns

module cache_controller import cache_pkg::*; (
    input logic clk,
    input logic rst,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_we,
    input cache_addr_t wb_adr,
    input logic hit,
    input logic valid,
    input logic dirty,
    input logic [tag_bits-1:0] victim_tag,
    output logic wb_ack,
    output logic tag_write,
    output logic dirty_set,
    output logic dirty_clear,
    output logic cpu_write,
    output logic fill_write,
    mem_bus_if.controller mem
);

    ctrl_state_t state;
    ctrl_state_t next_state;
    logic request;
    logic [word_sel_bits-1:0] wb_beat;
    logic [3:0] fill_beat;
    logic [word_sel_bits-1:0] fill_word;

    assign request = wb_cyc && wb_stb;

    // beat numbers follow from the contiguous state encoding.
    assign wb_beat = word_sel_bits'(state - st_wb0);
    assign fill_beat = 4'(state - st_fill0);
    assign fill_word = word_sel_bits'(fill_beat);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        wb_ack = 1'b0;
        tag_write = 1'b0;
        dirty_set = 1'b0;
        dirty_clear = 1'b0;
        cpu_write = 1'b0;
        fill_write = 1'b0;
        mem.mem_addr = '0;
        mem.read_mem = 1'b0;
        mem.write_mem = 1'b0;
        mem.array_offset = '0;
        mem.array_write = 1'b0;

        case (state)
            st_idle: begin
                if (request) begin
                    if (hit) begin
                        wb_ack = 1'b1;
                        cpu_write = wb_we;
                        dirty_set = wb_we;
                    end else if (valid && dirty) begin
                        next_state = st_wb0;
                    end else begin
                        next_state = st_fill0;
                    end
                end
            end

            // victim words go out to the address of the old tag.
            st_wb0, st_wb1, st_wb2, st_wb3: begin
                mem.write_mem = 1'b1;
                mem.array_write = 1'b1;
                mem.array_offset = wb_beat;
                mem.mem_addr.cache_view.tag = victim_tag;
                mem.mem_addr.cache_view.index = wb_adr.cache_view.index;
                mem.mem_addr.cache_view.offset = {wb_beat, 1'b0};
                if (state == st_wb3) begin
                    next_state = st_fill0;
                end else begin
                    next_state = ctrl_state_t'(state + 4'd1);
                end
            end

            // reads lead the array writes by the memory latency.
            st_fill0, st_fill1, st_fill2, st_fill3, st_fill4, st_fill5: begin
                if (fill_beat < words_per_line) begin
                    mem.read_mem = 1'b1;
                    mem.mem_addr.cache_view.tag = wb_adr.cache_view.tag;
                    mem.mem_addr.cache_view.index = wb_adr.cache_view.index;
                    mem.mem_addr.cache_view.offset = {fill_word, 1'b0};
                end
                if (fill_beat >= mem_read_latency) begin
                    fill_write = 1'b1;
                    mem.array_offset = word_sel_bits'(fill_beat - mem_read_latency);
                end
                if (state == st_fill5) begin
                    tag_write = 1'b1;
                    dirty_clear = 1'b1;
                    next_state = st_idle;
                end else begin
                    next_state = ctrl_state_t'(state + 4'd1);
                end
            end

            default: begin
                next_state = st_idle;
            end
        endcase
    end

endmodule

//--- source/cache_data_array.sv
`timescale 1ns/1ns

module cache_data_array import cache_pkg::*; (
    input logic clk,
    input cache_addr_t req_addr,
    input logic [word_bits-1:0] wdata,
    input logic cpu_write,
    input logic fill_write,
    output logic [word_bits-1:0] rdata,
    mem_bus_if.array mem
);

    logic [word_bits-1:0] lines [num_lines][words_per_line];
    logic [index_bits-1:0] index;
    logic [word_sel_bits-1:0] req_word;

    // byte bit of the offset is ignored.
    assign index = req_addr.cache_view.index;
    assign req_word = req_addr.cache_view.offset[offset_bits-1:1];

    // processor read port.
    assign rdata = lines[index][req_word];

    // write-back read port, quiet outside write-back.
    assign mem.mem_wdata = mem.array_write ? lines[index][mem.array_offset] : '0;

    always_ff @(posedge clk) begin
        if (fill_write) begin
            lines[index][mem.array_offset] <= mem.mem_rdata;
        end else if (cpu_write) begin
            lines[index][req_word] <= wdata;
        end
    end

endmodule

//--- source/cache_lookup.sv
`timescale 1ns/1ns

module cache_lookup import cache_pkg::*; (
    input logic clk,
    input logic rst,
    input cache_addr_t req_addr,
    input logic tag_write,
    input logic dirty_set,
    input logic dirty_clear,
    output logic hit,
    output logic valid,
    output logic dirty,
    output logic [tag_bits-1:0] victim_tag
);

    logic [tag_bits-1:0] tags [num_lines];
    logic [num_lines-1:0] valid_bits;
    logic [num_lines-1:0] dirty_bits;
    logic [index_bits-1:0] index;
    logic [tag_bits-1:0] req_tag;

    assign index = req_addr.cache_view.index;
    assign req_tag = req_addr.cache_view.tag;

    // stored line state at the request index.
    assign victim_tag = tags[index];
    assign valid = valid_bits[index];
    assign dirty = dirty_bits[index];
    assign hit = valid && (victim_tag == req_tag);

    // new tag goes in when a fill completes.
    always_ff @(posedge clk) begin
        if (tag_write) begin
            tags[index] <= req_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
        end else if (tag_write) begin
            valid_bits[index] <= 1'b1;
        end
    end

    // a finished fill always leaves the line clean.
    always_ff @(posedge clk) begin
        if (rst) begin
            dirty_bits <= '0;
        end else if (dirty_clear) begin
            dirty_bits[index] <= 1'b0;
        end else if (dirty_set) begin
            dirty_bits[index] <= 1'b1;
        end
    end

endmodule

//--- source/cache_pkg.sv
package cache_pkg;

    // address split and line geometry.
    localparam int tag_bits = 5;
    localparam int index_bits = 8;
    localparam int offset_bits = 3;
    localparam int word_bits = 16;
    localparam int words_per_line = 4;
    localparam int mem_read_latency = 2;

    localparam int addr_bits = tag_bits + index_bits + offset_bits;
    localparam int num_lines = 1 << index_bits;
    localparam int word_sel_bits = $clog2(words_per_line);

    // banked view of the same address.
    localparam int bank_bits = word_sel_bits;
    localparam int row_bits = addr_bits - bank_bits - 1;
    localparam int bank_depth = 1 << row_bits;

    typedef struct packed {
        logic [tag_bits-1:0] tag;
        logic [index_bits-1:0] index;
        logic [offset_bits-1:0] offset;
    } cache_fields_t;

    typedef struct packed {
        logic [row_bits-1:0] row;
        logic [bank_bits-1:0] bank;
        logic byte_sel;
    } bank_fields_t;

    typedef union packed {
        cache_fields_t cache_view;
        bank_fields_t bank_view;
    } cache_addr_t;

    typedef enum logic [3:0] {
        st_idle = 4'b0000,
        st_wb0 = 4'b0001,
        st_wb1 = 4'b0010,
        st_wb2 = 4'b0011,
        st_wb3 = 4'b0100,
        st_fill0 = 4'b0101,
        st_fill1 = 4'b0110,
        st_fill2 = 4'b0111,
        st_fill3 = 4'b1000,
        st_fill4 = 4'b1001,
        st_fill5 = 4'b1010,
        st_done = 4'b1100
    } ctrl_state_t;

endpackage

//--- source/cache_top.sv
`timescale 1ns/1ns

module cache_top import cache_pkg::*; (
    input logic clk,
    input logic rst,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_we,
    input logic [addr_bits-1:0] wb_adr,
    input logic [word_bits-1:0] wb_dat_i,
    output logic [word_bits-1:0] wb_dat_o,
    output logic wb_ack
);

    logic hit;
    logic valid;
    logic dirty;
    logic [tag_bits-1:0] victim_tag;
    logic tag_write;
    logic dirty_set;
    logic dirty_clear;
    logic cpu_write;
    logic fill_write;

    mem_bus_if mem_bus ();

    cache_lookup i_lookup (
        .clk (clk),
        .rst (rst),
        .req_addr (wb_adr),
        .tag_write (tag_write),
        .dirty_set (dirty_set),
        .dirty_clear (dirty_clear),
        .hit (hit),
        .valid (valid),
        .dirty (dirty),
        .victim_tag (victim_tag)
    );

    cache_controller i_controller (
        .clk (clk),
        .rst (rst),
        .wb_cyc (wb_cyc),
        .wb_stb (wb_stb),
        .wb_we (wb_we),
        .wb_adr (wb_adr),
        .hit (hit),
        .valid (valid),
        .dirty (dirty),
        .victim_tag (victim_tag),
        .wb_ack (wb_ack),
        .tag_write (tag_write),
        .dirty_set (dirty_set),
        .dirty_clear (dirty_clear),
        .cpu_write (cpu_write),
        .fill_write (fill_write),
        .mem (mem_bus.controller)
    );

    cache_data_array i_data_array (
        .clk (clk),
        .req_addr (wb_adr),
        .wdata (wb_dat_i),
        .cpu_write (cpu_write),
        .fill_write (fill_write),
        .rdata (wb_dat_o),
        .mem (mem_bus.array)
    );

    banked_memory i_memory (
        .clk (clk),
        .rst (rst),
        .mem (mem_bus.memory)
    );

endmodule

//--- source/mem_bus_if.sv
`timescale 1ns/1ns

interface mem_bus_if import cache_pkg::*; ();

    cache_addr_t mem_addr;
    logic read_mem;
    logic write_mem;
    logic [word_bits-1:0] mem_wdata;
    logic [word_bits-1:0] mem_rdata;
    // word of the line addressed during a burst.
    logic [word_sel_bits-1:0] array_offset;
    // high while the array sources write-back data.
    logic array_write;

    modport controller (
        output mem_addr,
        output read_mem,
        output write_mem,
        output array_offset,
        output array_write
    );

    modport memory (
        input mem_addr,
        input read_mem,
        input write_mem,
        input mem_wdata,
        output mem_rdata
    );

    modport array (
        input array_offset,
        input array_write,
        input mem_rdata,
        output mem_wdata
    );

endinterface

//--- testbench/cache_properties.sv
`timescale 1ns/1ns

module cache_properties import cache_pkg::*; (
    input logic clk,
    input logic rst,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input ctrl_state_t state,
    input logic read_mem,
    input logic write_mem
);

    ack_needs_request: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> (wb_cyc && wb_stb))
        else $error("wb_ack without cyc and stb");

    one_memory_op: assert property (@(posedge clk) disable iff (rst)
        !(read_mem && write_mem))
        else $error("memory read and write in the same cycle");

    ack_only_in_idle: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> (state == st_idle))
        else $error("wb_ack outside the idle state");

    // first cycle after a reset edge.
    ack_low_after_reset: assert property (@(posedge clk)
        rst |=> !wb_ack)
        else $error("wb_ack high right after reset");

endmodule

bind cache_controller cache_properties i_properties (
    .clk (clk),
    .rst (rst),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_ack (wb_ack),
    .state (state),
    .read_mem (mem.read_mem),
    .write_mem (mem.write_mem)
);

//--- testbench/cache_tb.sv
`timescale 1ns/1ns

module cache_tb import cache_pkg::*; ();

    localparam int clk_period = 10;
    localparam int reset_cycles = 8;
    localparam string data_file = "testbench/cache_testdata.txt";

    // cycles from the first request cycle to the ack cycle.
    localparam int hit_wait = 0;
    localparam int clean_miss_wait = words_per_line + mem_read_latency + 1;
    localparam int dirty_miss_wait = clean_miss_wait + words_per_line;
    // worst access is a dirty miss plus ack cycle, ack-low cycle and longest gap.
    localparam int cycles_per_access = dirty_miss_wait + 2 + 3;

    logic clk;
    logic rst;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [15:0] wb_adr;
    logic [15:0] wb_dat_i;
    logic [15:0] wb_dat_o;
    logic wb_ack;

    logic [7:0] op_q[$];
    logic [15:0] addr_q[$];
    logic [15:0] wdata_q[$];
    logic [15:0] rdata_q[$];
    logic [7:0] class_q[$];
    int num_tests;
    bit loaded;
    logic [31:0] lfsr_state;

    cache_top i_dut (
        .clk (clk),
        .rst (rst),
        .wb_cyc (wb_cyc),
        .wb_stb (wb_stb),
        .wb_we (wb_we),
        .wb_adr (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, actual, expected);
            stop_with_failure();
        end
    endtask

    // galois form, taps 32 22 2 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end else begin
            return s >> 1;
        end
    endfunction

    task automatic random_gap(output int gap);
        logic [1:0] bits;
        for (int b = 0; b < 2; b++) begin
            bits[b] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
        gap = int'(bits);
    endtask

    function automatic int expected_wait(input logic [7:0] cls);
        case (cls)
            "H": return hit_wait;
            "M": return clean_miss_wait;
            default: return dirty_miss_wait;
        endcase
    endfunction

    task automatic load_tests();
        int fd;
        int fields;
        string line;
        logic [7:0] op;
        logic [15:0] addr;
        logic [15:0] wdata;
        logic [15:0] rdata;
        logic [7:0] cls;
        fd = $fopen(data_file, "r");
        if (fd == 0) begin
            $display("could not open the test data file %s", data_file);
            stop_with_failure();
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                fields = $sscanf(line, "%s %h %h %h %s", op, addr, wdata, rdata, cls);
                if (fields != 5 || !(op inside {"R", "W"}) || !(cls inside {"H", "M", "D"})) begin
                    $display("malformed test data line: %s", line);
                    stop_with_failure();
                end else begin
                    op_q.push_back(op);
                    addr_q.push_back(addr);
                    wdata_q.push_back(wdata);
                    rdata_q.push_back(rdata);
                    class_q.push_back(cls);
                end
            end
            $fclose(fd);
            num_tests = op_q.size();
        end
    endtask

    // one wishbone classic cycle, held until ack.
    task automatic run_access(input int i);
        int waited;
        bit acked;
        waited = 0;
        acked = 1'b0;
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= (op_q[i] == "W");
        wb_adr <= addr_q[i];
        wb_dat_i <= wdata_q[i];
        while (!acked) begin
            @(posedge clk);
            if (wb_ack) begin
                acked = 1'b1;
            end else if (waited >= dirty_miss_wait + 4) begin
                $display("wb_ack never came for access %0d at address 0x%h", i, addr_q[i]);
                stop_with_failure();
            end else begin
                waited++;
            end
        end
        check_value("ack_wait", waited, expected_wait(class_q[i]));
        if (op_q[i] == "R") begin
            check_value("wb_dat_o", wb_dat_o, rdata_q[i]);
        end
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
        // ack must be a single-cycle pulse.
        @(posedge clk);
        check_value("wb_ack", wb_ack, 1'b0);
    endtask

    initial begin
        int gap;
        rst = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_i = '0;
        lfsr_state = 32'ha0950c45;
        num_tests = 0;
        loaded = 1'b0;
        load_tests();
        loaded = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        // the first request meets the cycle right after reset.
        for (int i = 0; i < num_tests; i++) begin
            if (i > 0) begin
                random_gap(gap);
                repeat (gap) @(posedge clk);
            end
            run_access(i);
        end
        $display("Simulation passed");
        $finish;
    end

    initial begin
        wait (loaded);
        #((num_tests * cycles_per_access + reset_cycles + 4) * clk_period);
        $display("watchdog expired, wb_ack never came within the allowed time");
        stop_with_failure();
    end

endmodule

//--- testbench/cache_testdata.txt
# columns: op (R or W), address, write data, expected read data (all hex),
# latency class (H hit, M clean miss, D dirty miss)
R 0010 0000 0000 M
R 0012 0000 0000 H
W 0014 1111 0000 H
R 0014 0000 1111 H
R 0010 0000 0000 H
R 0016 0000 0000 H
W 0020 aaaa 0000 M
W 0022 bbbb 0000 H
R 0020 0000 aaaa H
R 0022 0000 bbbb H
R 0024 0000 0000 H
R 0810 0000 0000 D
R 0014 0000 1111 M
R 0810 0000 0000 M
R 1010 0000 0000 M
W 0826 cccc 0000 D
R 0820 0000 0000 H
R 0826 0000 cccc H
R 0022 0000 bbbb D
R 0020 0000 aaaa H
R 0826 0000 cccc M
W f8f6 5a5a 0000 M
R f8f6 0000 5a5a H
R f0f6 0000 0000 D
R f8f6 0000 5a5a M
R f8f0 0000 0000 H
W 0002 0001 0000 M
R 0003 0000 0001 H
R 7fff 0000 0000 M
